// ==== mac_defs.svh ====
// widths assume MUL_STEPS * MUL_SLICE_W == MAC_W and MAC_W + MAC_SHIFT == MAC_RES_W
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// operand and result widths
`define MAC_W 56
`define MAC_RES_W 110
`define MAC_PROD_W 112

// addend is placed above the product's integer part
`define MAC_SHIFT 54

// iterative multiplier geometry
`define MUL_SLICE_W 14
`define MUL_STEPS 4

`endif

// ==== mac_pkg.sv ====
// shared mantissa datapath types; widths come from mac_defs.svh, d is truncated to MAC_RES_W
package mac_pkg;

    `include "mac_defs.svh"

    // plain vectors with a meaning
    typedef logic signed [`MAC_W-1:0] mac_word_t;
    typedef logic [`MAC_RES_W-1:0] mac_res_t;
    typedef logic signed [`MAC_PROD_W-1:0] mac_prod_t;
    typedef logic lane_id_t;

    // lane input bundle, valid is a single-cycle strobe
    typedef struct packed {
        logic valid;
        logic op;
        mac_word_t a;
        mac_word_t b;
        mac_word_t c;
    } mac_in_t;

    // lane output bundle, ready pulses once per operation
    typedef struct packed {
        logic ready;
        mac_res_t d;
    } mac_out_t;

    // multiplier command
    typedef struct packed {
        logic start;
        mac_word_t a;
        mac_word_t b;
    } mul_req_t;

    // multiplier response
    typedef struct packed {
        logic valid;
        mac_prod_t prod;
    } mul_rsp_t;

    // lane sequencing
    typedef enum logic [2:0] {
        IDLE,
        REQ,
        MUL,
        ADD,
        OUT
    } mac_state_t;

endpackage

// ==== mul_iter.sv ====
// signed 56x56 multiplier, one slice per cycle; start is ignored while a product is in flight
`include "mac_defs.svh"

module mul_iter (
    input  logic              clk,
    input  logic              rst_n,
    input  mac_pkg::mul_req_t req_i,
    output mac_pkg::mul_rsp_t rsp_o
);

    import mac_pkg::*;

    localparam int STEP_W = $clog2(`MUL_STEPS);
    localparam int PART_W = `MAC_W + `MUL_SLICE_W;

    // control state
    logic busy_q;
    logic valid_q;
    logic [STEP_W-1:0] step_q;
    logic last_step;

    // operand magnitudes and product sign
    logic [`MAC_W-1:0] a_mag_q;
    logic [`MAC_W-1:0] b_mag_q;
    logic neg_q;

    // accumulation
    logic [`MUL_SLICE_W-1:0] b_slice;
    logic [PART_W-1:0] partial;
    logic [`MAC_PROD_W-1:0] acc_q;
    logic [`MAC_PROD_W-1:0] acc_next;
    mac_prod_t prod_q;

    logic start_ok;

    assign start_ok = req_i.start && !busy_q;
    assign last_step = (step_q == STEP_W'(`MUL_STEPS - 1));

    // one slice of b against the whole of a, shifted into place
    always_comb begin
        b_slice = b_mag_q[step_q*`MUL_SLICE_W +: `MUL_SLICE_W];
        partial = a_mag_q * b_slice;
        acc_next = acc_q
            + ({{(`MAC_PROD_W - PART_W){1'b0}}, partial} << (step_q * `MUL_SLICE_W));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            step_q  <= '0;
        end else begin
            valid_q <= 1'b0;
            if (start_ok) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (last_step) begin
                    busy_q  <= 1'b0;
                    valid_q <= 1'b1;
                end
            end
        end
    end

    // datapath registers, qualified by the control above
    always_ff @(posedge clk) begin
        if (start_ok) begin
            // magnitude of the most negative value still fits unsigned
            a_mag_q <= req_i.a[`MAC_W-1] ? -req_i.a : req_i.a;
            b_mag_q <= req_i.b[`MAC_W-1] ? -req_i.b : req_i.b;
            neg_q   <= req_i.a[`MAC_W-1] ^ req_i.b[`MAC_W-1];
            acc_q   <= '0;
        end else if (busy_q) begin
            acc_q <= acc_next;
            if (last_step) begin
                // sign restored only once, on the final sum
                prod_q <= neg_q ? -acc_next : acc_next;
            end
        end
    end

    assign rsp_o.valid = valid_q;
    assign rsp_o.prod  = prod_q;

endmodule

// ==== mul_arbiter.sv ====
// two-lane round-robin arbiter; one product in flight at a time, lane 0 first after reset
module mul_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [1:0]         req_i,
    input  mac_pkg::mac_word_t a0_i,
    input  mac_pkg::mac_word_t b0_i,
    input  mac_pkg::mac_word_t a1_i,
    input  mac_pkg::mac_word_t b1_i,
    output logic [1:0]         grant_o,
    output mac_pkg::mul_req_t  mul_req_o,
    input  mac_pkg::mul_rsp_t  mul_rsp_i,
    output mac_pkg::mul_rsp_t  rsp0_o,
    output mac_pkg::mul_rsp_t  rsp1_o
);

    import mac_pkg::*;

    logic busy_q;
    lane_id_t owner_q;
    // lane that wins the next tie
    lane_id_t prio_q;

    lane_id_t winner;
    logic grant_any;

    always_comb begin
        if (req_i == 2'b11) begin
            winner = prio_q;
        end else begin
            winner = req_i[1];
        end
    end

    assign grant_any = !busy_q && (|req_i);

    // one-cycle grant, same cycle as the start
    assign grant_o[0] = grant_any && (winner == 1'b0);
    assign grant_o[1] = grant_any && (winner == 1'b1);

    assign mul_req_o.start = grant_any;
    assign mul_req_o.a     = winner ? a1_i : a0_i;
    assign mul_req_o.b     = winner ? b1_i : b0_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
            prio_q  <= 1'b0;
        end else begin
            if (grant_any) begin
                busy_q  <= 1'b1;
                owner_q <= winner;
                prio_q  <= ~winner;
            end else if (mul_rsp_i.valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    // product goes to both, valid only to the owner
    assign rsp0_o.prod  = mul_rsp_i.prod;
    assign rsp1_o.prod  = mul_rsp_i.prod;
    assign rsp0_o.valid = mul_rsp_i.valid && (owner_q == 1'b0);
    assign rsp1_o.valid = mul_rsp_i.valid && (owner_q == 1'b1);

endmodule

// ==== fp_mac.sv ====
// one lane of d = (a << 54) +/- b*c mod 2^110; valid outside IDLE is dropped, d holds until next op
`include "mac_defs.svh"

module fp_mac (
    input  logic               clk,
    input  logic               rst_n,
    input  mac_pkg::mac_in_t   mac_i,
    output mac_pkg::mac_out_t  mac_o,
    output logic               mul_req_o,
    output mac_pkg::mac_word_t mul_a_o,
    output mac_pkg::mac_word_t mul_b_o,
    input  logic               grant_i,
    input  mac_pkg::mul_rsp_t  mul_rsp_i
);

    import mac_pkg::*;

    mac_state_t state_q;
    mac_state_t state_n;

    // latched operands
    logic op_q;
    mac_word_t a_q;
    mac_word_t b_q;
    mac_word_t c_q;
    logic a_zero;

    // accumulate path
    mac_res_t prod_sel;
    mac_res_t addend;
    mac_res_t term;
    mac_res_t sum;

    mac_res_t d_q;
    logic ready_q;

    logic accept;
    logic load_bare;
    logic load_sum;

    assign accept    = (state_q == IDLE) && mac_i.valid;
    assign a_zero    = (a_q == '0);
    assign load_bare = (state_q == MUL) && mul_rsp_i.valid && a_zero;
    assign load_sum  = (state_q == ADD);

    always_comb begin
        state_n = state_q;
        case (state_q)
            IDLE: begin
                if (mac_i.valid) begin
                    state_n = REQ;
                end
            end
            REQ: begin
                if (grant_i) begin
                    state_n = MUL;
                end
            end
            MUL: begin
                if (mul_rsp_i.valid) begin
                    // zero addend skips the add cycle
                    state_n = a_zero ? OUT : ADD;
                end
            end
            ADD: state_n = OUT;
            OUT: state_n = IDLE;
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_n;
            ready_q <= load_bare || load_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= mac_i.op;
            a_q  <= mac_i.a;
            b_q  <= mac_i.b;
            c_q  <= mac_i.c;
        end
        if (load_bare || load_sum) begin
            d_q <= load_sum ? sum : term;
        end
    end

    // multiplier output holds the product through the add cycle
    // low 110 bits only, so negation wraps mod 2^110
    assign prod_sel = mul_rsp_i.prod[`MAC_RES_W-1:0];
    assign term     = op_q ? -prod_sel : prod_sel;
    assign addend   = {a_q, {`MAC_SHIFT{1'b0}}};
    assign sum      = addend + term;

    // request held as a level until granted
    assign mul_req_o = (state_q == REQ);
    assign mul_a_o   = b_q;
    assign mul_b_o   = c_q;

    assign mac_o.ready = ready_q;
    assign mac_o.d     = d_q;

endmodule

// ==== mac_pair_top.sv ====
// two MAC lanes sharing one multiplier; latency per lane grows under contention
module mac_pair_top (
    input  logic              clk,
    input  logic              rst_n,
    input  mac_pkg::mac_in_t  lane0_i,
    input  mac_pkg::mac_in_t  lane1_i,
    output mac_pkg::mac_out_t lane0_o,
    output mac_pkg::mac_out_t lane1_o
);

    import mac_pkg::*;

    logic [1:0] lane_req;
    logic [1:0] lane_grant;
    mac_word_t a0;
    mac_word_t b0;
    mac_word_t a1;
    mac_word_t b1;
    mul_req_t mul_req;
    mul_rsp_t mul_rsp;
    mul_rsp_t rsp0;
    mul_rsp_t rsp1;

    fp_mac u_mac0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mac_i     (lane0_i),
        .mac_o     (lane0_o),
        .mul_req_o (lane_req[0]),
        .mul_a_o   (a0),
        .mul_b_o   (b0),
        .grant_i   (lane_grant[0]),
        .mul_rsp_i (rsp0)
    );

    fp_mac u_mac1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mac_i     (lane1_i),
        .mac_o     (lane1_o),
        .mul_req_o (lane_req[1]),
        .mul_a_o   (a1),
        .mul_b_o   (b1),
        .grant_i   (lane_grant[1]),
        .mul_rsp_i (rsp1)
    );

    mul_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (lane_req),
        .a0_i      (a0),
        .b0_i      (b0),
        .a1_i      (a1),
        .b1_i      (b1),
        .grant_o   (lane_grant),
        .mul_req_o (mul_req),
        .mul_rsp_i (mul_rsp),
        .rsp0_o    (rsp0),
        .rsp1_o    (rsp1)
    );

    mul_iter u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (mul_req),
        .rsp_o (mul_rsp)
    );

endmodule

// ==== tb_mac_pair.sv ====
// self-checking testbench; each ready wait gives up after 100 cycles, random pairs use seed 52899
`include "mac_defs.svh"

module tb_mac_pair;

    import mac_pkg::*;

    localparam int TIMEOUT = 100;
    localparam int MAX_VEC = 16;
    localparam int NUM_RAND = 8;

    // one table row, same_cycle pairs the row with the one before it
    typedef struct packed {
        lane_id_t lane;
        logic op;
        mac_word_t a;
        mac_word_t b;
        mac_word_t c;
        logic same_cycle;
    } test_vec_t;

    logic clk;
    logic rst_n;
    mac_in_t lane0_i;
    mac_in_t lane1_i;
    mac_out_t lane0_o;
    mac_out_t lane1_o;

    test_vec_t vec_tbl[MAX_VEC];
    int vec_num;
    int err_cnt;
    int pass_cnt;
    int fail_cnt;
    int test_num;

    // ready cycles seen per lane, and the d that came with the last one
    int rdy_cnt[2];
    mac_res_t last_d[2];

    mac_pair_top u_mac_pair_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .lane0_i (lane0_i),
        .lane1_i (lane1_i),
        .lane0_o (lane0_o),
        .lane1_o (lane1_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (lane0_o.ready) begin
            rdy_cnt[0] = rdy_cnt[0] + 1;
            last_d[0] = lane0_o.d;
        end
        if (lane1_o.ready) begin
            rdy_cnt[1] = rdy_cnt[1] + 1;
            last_d[1] = lane1_o.d;
        end
    end

    // reference: (a << 54) +/- b*c, kept to the low 110 bits
    function automatic mac_res_t expected_d(logic op, mac_word_t a, mac_word_t b, mac_word_t c);
        logic signed [127:0] wa;
        logic signed [127:0] wb;
        logic signed [127:0] wc;
        logic signed [127:0] prod;
        logic signed [127:0] acc;
        wa = a;
        wb = b;
        wc = c;
        prod = wb * wc;
        if (op) begin
            acc = (wa <<< `MAC_SHIFT) - prod;
        end else begin
            acc = (wa <<< `MAC_SHIFT) + prod;
        end
        return acc[`MAC_RES_W-1:0];
    endfunction

    function automatic mac_word_t rand_word();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[`MAC_W-1:0];
    endfunction

    function automatic mac_in_t to_in(test_vec_t v);
        mac_in_t m;
        m.valid = 1'b1;
        m.op = v.op;
        m.a = v.a;
        m.b = v.b;
        m.c = v.c;
        return m;
    endfunction

    task automatic add_vec(input lane_id_t lane, input logic op, input mac_word_t a,
                           input mac_word_t b, input mac_word_t c, input logic same_cycle);
        vec_tbl[vec_num] = {lane, op, a, b, c, same_cycle};
        vec_num++;
    endtask

    task automatic wait_ready(input int lane, input int base, output bit answered);
        int cycles;
        cycles = 0;
        while ((rdy_cnt[lane] - base) < 1 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        answered = (rdy_cnt[lane] - base) >= 1;
        if (!answered) begin
            $display("lane %0d never answered within %0d cycles", lane, TIMEOUT);
            err_cnt++;
        end
    endtask

    task automatic check_lane(input int lane, input int base, input mac_res_t exp_d,
                              input bit answered);
        int pulses;
        pulses = rdy_cnt[lane] - base;
        if (answered && pulses != 1) begin
            $display("lane %0d held ready for %0d cycles instead of one", lane, pulses);
            err_cnt++;
        end
        if (answered && last_d[lane] !== exp_d) begin
            $display("FAILED at time %0t: lane %0d d=%h expected %h",
                     $time, lane, last_d[lane], exp_d);
            err_cnt++;
        end
    endtask

    // lane 1 starts gap cycles after lane 0; retrig strobes lane 0 again while busy
    task automatic run_case(input string name, input bit en0, input mac_in_t in0,
                            input bit en1, input mac_in_t in1, input int gap,
                            input bit retrig, input mac_in_t in_retrig);
        int base0;
        int base1;
        int last_t;
        int errs_before;
        bit ans0;
        bit ans1;
        mac_res_t exp0;
        mac_res_t exp1;
        base0 = rdy_cnt[0];
        base1 = rdy_cnt[1];
        errs_before = err_cnt;
        exp0 = expected_d(in0.op, in0.a, in0.b, in0.c);
        exp1 = expected_d(in1.op, in1.a, in1.b, in1.c);
        last_t = gap;
        if (retrig && last_t < 2) begin
            last_t = 2;
        end
        for (int t = 0; t <= last_t; t++) begin
            @(posedge clk);
            lane0_i <= '0;
            lane1_i <= '0;
            if (en0 && t == 0) begin
                lane0_i <= in0;
                lane0_i.valid <= 1'b1;
            end
            if (retrig && t == 2) begin
                lane0_i <= in_retrig;
                lane0_i.valid <= 1'b1;
            end
            if (en1 && t == gap) begin
                lane1_i <= in1;
                lane1_i.valid <= 1'b1;
            end
        end
        @(posedge clk);
        lane0_i <= '0;
        lane1_i <= '0;
        ans0 = 1'b0;
        ans1 = 1'b0;
        if (en0) begin
            wait_ready(0, base0, ans0);
        end
        if (en1) begin
            wait_ready(1, base1, ans1);
        end
        // a few more cycles so a stray second ready would be counted
        repeat (4) @(posedge clk);
        if (en0) begin
            check_lane(0, base0, exp0, ans0);
        end
        if (en1) begin
            check_lane(1, base1, exp1, ans1);
        end
        test_num++;
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: wrong", test_num, name);
        end
    endtask

    initial begin
        mac_in_t in0;
        mac_in_t in1;
        mac_in_t idle_in;
        int i;
        int gap;

        void'($urandom(52899));
        err_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        test_num = 0;
        vec_num = 0;
        idle_in = '0;
        rst_n = 1'b0;
        lane0_i = '0;
        lane1_i = '0;

        // lane, op, a, b, c, same_cycle
        add_vec(1'b0, 1'b0, 56'sd3, 56'sd5, 56'sd7, 1'b0);
        add_vec(1'b1, 1'b0, 56'h123456789abcde, 56'h00000123456789, 56'h0000000abcdef0, 1'b0);
        add_vec(1'b0, 1'b1, 56'sd16, -56'sd3, 56'sd9, 1'b0);
        add_vec(1'b1, 1'b1, 56'h7fffffffffffff, -56'sd1, 56'h80000000000000, 1'b0);
        add_vec(1'b0, 1'b1, -56'sd77, -56'sd123456, -56'sd654321, 1'b0);
        add_vec(1'b0, 1'b0, 56'sd0, 56'h000000deadbeef, -56'sd2, 1'b0);
        add_vec(1'b1, 1'b1, 56'sd0, 56'h80000000000000, 56'h80000000000000, 1'b0);
        add_vec(1'b0, 1'b0, 56'sd1, 56'h00ffff0000ffff, 56'h0f0f0f0f0f0f0f, 1'b0);
        add_vec(1'b1, 1'b1, -56'sd9, 56'h7fffffffffffff, 56'h7fffffffffffff, 1'b1);
        add_vec(1'b1, 1'b0, 56'h00000000abcdef, -56'sd1000, 56'sd999, 1'b0);
        add_vec(1'b0, 1'b1, 56'sd0, 56'h55555555555555, -56'sd3, 1'b1);
        add_vec(1'b0, 1'b0, -56'sd5, 56'h7fffffffffffff, 56'h7fffffffffffff, 1'b0);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // no ready may appear before the first valid
        repeat (10) @(posedge clk);
        test_num++;
        if (rdy_cnt[0] != 0 || rdy_cnt[1] != 0) begin
            $display("ready went high after reset with no valid applied");
            err_cnt++;
            fail_cnt++;
            $display("test %0d idle after reset: wrong", test_num);
        end else begin
            pass_cnt++;
            $display("test %0d idle after reset: ok", test_num);
        end

        i = 0;
        while (i < vec_num) begin
            if (i + 1 < vec_num && vec_tbl[i+1].same_cycle) begin
                // both lanes strobe in one cycle
                if (vec_tbl[i].lane == 1'b0) begin
                    in0 = to_in(vec_tbl[i]);
                    in1 = to_in(vec_tbl[i+1]);
                end else begin
                    in0 = to_in(vec_tbl[i+1]);
                    in1 = to_in(vec_tbl[i]);
                end
                run_case("table pair", 1'b1, in0, 1'b1, in1, 0, 1'b0, idle_in);
                i = i + 2;
            end else begin
                if (vec_tbl[i].lane == 1'b0) begin
                    run_case("table lane 0", 1'b1, to_in(vec_tbl[i]), 1'b0, idle_in,
                             0, 1'b0, idle_in);
                end else begin
                    run_case("table lane 1", 1'b0, idle_in, 1'b1, to_in(vec_tbl[i]),
                             0, 1'b0, idle_in);
                end
                i = i + 1;
            end
        end

        // second strobe while lane 0 is busy must be dropped
        in0 = {1'b1, 1'b0, 56'sd21, -56'sd4, 56'sd11};
        in1 = {1'b1, 1'b1, 56'sd99, 56'sd99, 56'sd99};
        run_case("busy ignore", 1'b1, in0, 1'b0, idle_in, 0, 1'b1, in1);

        // random pairs, same cycle or staggered by up to three cycles
        for (int n = 0; n < NUM_RAND; n++) begin
            in0 = {1'b1, 1'($urandom), rand_word(), rand_word(), rand_word()};
            in1 = {1'b1, 1'($urandom), rand_word(), rand_word(), rand_word()};
            if ($urandom_range(3) == 0) begin
                in0.a = '0;
            end
            if ($urandom_range(3) == 0) begin
                in1.a = '0;
            end
            gap = $urandom_range(3);
            run_case("random pair", 1'b1, in0, 1'b1, in1, gap, 1'b0, idle_in);
        end

        $display("%0d tests passed, %0d tests failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
mac_pkg.sv
mul_iter.sv
mul_arbiter.sv
fp_mac.sv
mac_pair_top.sv
tb_mac_pair.sv
